// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_proc_block
FILELIST  ?= proc_block.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: proc_block.f
src/block_pkg.sv
src/dmem_bus_if.sv
src/mini_core.sv
src/mem_sys.sv
src/io_regs.sv
src/proc_block.sv
tests/tb_proc_block.sv

// File: src/block_pkg.sv
package block_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////
  localparam int data_width      = 32;
  localparam int strb_width      = 4;
  localparam int addr_width      = 10;
  localparam int dma_addr_width  = 11;
  localparam int imem_words      = 256;
  localparam int imem_addr_width = 8;
  localparam int dmem_words      = 512;
  localparam int dmem_addr_width = 9;
  localparam int core_id_width   = 4;
  localparam int reg_count       = 8;
  localparam int reg_idx_width   = 3;

  //////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////
  // Both top bits set selects the IO region
  localparam logic [addr_width-1:0] io_base = 10'd768;

  localparam int io_off_width = 2;
  localparam logic [io_off_width-1:0] io_in_status = 2'd0;
  localparam logic [io_off_width-1:0] io_in_desc   = 2'd1;
  localparam logic [io_off_width-1:0] io_out_desc  = 2'd2;
  localparam logic [io_off_width-1:0] io_status    = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Instruction set
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    op_li   = 4'd0,
    op_addi = 4'd1,
    op_add  = 4'd2,
    op_ld   = 4'd3,
    op_st   = 4'd4,
    op_bnz  = 4'd5,
    op_halt = 4'd6
  } opcode_t;

  // Field positions inside a 32-bit instruction
  localparam int op_msb    = 31;
  localparam int op_lsb    = 28;
  localparam int rd_msb    = 27;
  localparam int rd_lsb    = 25;
  localparam int rs_msb    = 24;
  localparam int rs_lsb    = 22;
  localparam int imm_width = 16;

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_load_wait,
    st_halted
  } core_state_t;

  // Byte-lane merge of a strobed write
  function automatic logic [data_width-1:0] merge_strb(
    input logic [data_width-1:0] old_word,
    input logic [data_width-1:0] new_word,
    input logic [strb_width-1:0] strb
  );
    logic [data_width-1:0] merged;
    merged = old_word;
    for (int i = 0; i < strb_width; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// File: src/dmem_bus_if.sv
`timescale 1ns/10ps

interface dmem_bus_if;

  import block_pkg::*;

  logic                  en;
  logic                  wen;
  logic [strb_width-1:0] strb;
  logic [addr_width-1:0] addr;
  logic [data_width-1:0] wr_data;
  logic [data_width-1:0] rd_data;
  logic                  rd_valid;

  // Requester side
  modport core (
    output en, wen, strb, addr, wr_data,
    input  rd_data, rd_valid
  );

  // Responders, both answer one cycle after en
  modport memory (
    input  en, wen, strb, addr, wr_data,
    output rd_data, rd_valid
  );

  modport io (
    input  en, wen, strb, addr, wr_data,
    output rd_data, rd_valid
  );

endinterface

// File: src/io_regs.sv
`timescale 1ns/10ps

module io_regs (
  input  logic                                sys_clk,
  input  logic                                sys_rst,
  dmem_bus_if.io                              dbus,
  input  logic [block_pkg::core_id_width-1:0] core_id,
  input  logic [block_pkg::data_width-1:0]    in_desc,
  input  logic                                in_desc_valid,
  output logic                                in_desc_taken,
  output logic [block_pkg::data_width-1:0]    out_desc,
  output logic                                out_desc_valid,
  input  logic                                out_desc_ready
);

  import block_pkg::*;

  logic [io_off_width-1:0] offset;
  logic                    rd_req;
  logic                    out_wr;
  logic [data_width-1:0]   rd_word;

  assign offset = dbus.addr[io_off_width-1:0];
  assign rd_req = dbus.en && !dbus.wen;
  assign out_wr = dbus.en && dbus.wen && (offset == io_out_desc);

  always_comb begin
    case (offset)
      io_in_status: rd_word = {{(data_width-1){1'b0}}, in_desc_valid};
      io_in_desc:   rd_word = in_desc;
      io_out_desc:  rd_word = out_desc;
      io_status:    rd_word = {{(data_width-8){1'b0}}, core_id, 3'b000, out_desc_valid};
      default:      rd_word = '0;
    endcase
  end

  // Taken pulse follows the read of the in descriptor
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      dbus.rd_valid  <= 1'b0;
      in_desc_taken  <= 1'b0;
      out_desc_valid <= 1'b0;
    end else begin
      dbus.rd_valid <= rd_req;
      in_desc_taken <= rd_req && (offset == io_in_desc) && in_desc_valid;
      if (out_wr) begin
        out_desc_valid <= 1'b1;
      end else if (out_desc_ready) begin
        out_desc_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rd_req) begin
      dbus.rd_data <= rd_word;
    end
    if (out_wr) begin
      out_desc <= merge_strb(out_desc, dbus.wr_data, dbus.strb);
    end
  end

  // Software polls out pending before it writes
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    out_wr |-> !out_desc_valid);

endmodule

// File: src/mem_sys.sv
`timescale 1ns/10ps

module mem_sys (
  input  logic                                  sys_clk,
  input  logic                                  sys_rst,
  input  logic                                  dma_wr_en,
  input  logic [block_pkg::dma_addr_width-1:0]  dma_wr_addr,
  input  logic [block_pkg::data_width-1:0]      dma_wr_data,
  input  logic [block_pkg::strb_width-1:0]      dma_wr_strb,
  input  logic                                  dma_rd_en,
  input  logic [block_pkg::dma_addr_width-1:0]  dma_rd_addr,
  output logic                                  dma_rd_resp_valid,
  output logic [block_pkg::data_width-1:0]      dma_rd_resp_data,
  input  logic [block_pkg::imem_addr_width-1:0] imem_addr,
  output logic [block_pkg::data_width-1:0]      imem_rd_data,
  dmem_bus_if.memory                            dbus
);

  import block_pkg::*;

  logic [data_width-1:0]      imem [imem_words];
  logic [data_width-1:0]      dmem [dmem_words];

  logic                       dma_imem_we;
  logic                       dma_dmem_we;
  logic                       core_we;
  logic [dmem_addr_width-1:0] dma_wr_word;
  logic [dmem_addr_width-1:0] dma_rd_word;
  logic [dmem_addr_width-1:0] core_word;
  logic [data_width-1:0]      dma_imem_q;
  logic [data_width-1:0]      dma_dmem_q;
  logic                       dma_rd_imem_r;

  // Top DMA address bit picks instruction memory
  assign dma_imem_we = dma_wr_en && dma_wr_addr[dma_addr_width-1];
  assign dma_dmem_we = dma_wr_en && !dma_wr_addr[dma_addr_width-1];
  assign dma_wr_word = dma_wr_addr[dmem_addr_width-1:0];
  assign dma_rd_word = dma_rd_addr[dmem_addr_width-1:0];
  assign core_word   = dbus.addr[dmem_addr_width-1:0];
  assign core_we     = dbus.en && dbus.wen;

  //////////////////////////////////////////////////////////////////////
  // Instruction memory
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (dma_imem_we) begin
      imem[dma_wr_word[imem_addr_width-1:0]] <=
        merge_strb(imem[dma_wr_word[imem_addr_width-1:0]], dma_wr_data, dma_wr_strb);
    end
    imem_rd_data <= imem[imem_addr];
    if (dma_rd_en) begin
      dma_imem_q <= imem[dma_rd_word[imem_addr_width-1:0]];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data memory, DMA port and core port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (dma_dmem_we) begin
      dmem[dma_wr_word] <= merge_strb(dmem[dma_wr_word], dma_wr_data, dma_wr_strb);
    end
    if (core_we) begin
      dmem[core_word] <= merge_strb(dmem[core_word], dbus.wr_data, dbus.strb);
    end
    if (dma_rd_en) begin
      dma_dmem_q    <= dmem[dma_rd_word];
      dma_rd_imem_r <= dma_rd_addr[dma_addr_width-1];
    end
    if (dbus.en && !dbus.wen) begin
      dbus.rd_data <= dmem[core_word];
    end
  end

  // Both responses come one cycle after the request
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      dma_rd_resp_valid <= 1'b0;
      dbus.rd_valid     <= 1'b0;
    end else begin
      dma_rd_resp_valid <= dma_rd_en;
      dbus.rd_valid     <= dbus.en && !dbus.wen;
    end
  end

  assign dma_rd_resp_data = dma_rd_imem_r ? dma_imem_q : dma_dmem_q;

  // DMA and core must not write the same word together
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    !(dma_dmem_we && core_we && (dma_wr_word == core_word)));

endmodule

// File: src/mini_core.sv
`timescale 1ns/10ps

module mini_core (
  input  logic                                  sys_clk,
  input  logic                                  sys_rst,
  input  logic                                  core_rst,
  output logic [block_pkg::imem_addr_width-1:0] imem_addr,
  input  logic [block_pkg::data_width-1:0]      imem_rd_data,
  dmem_bus_if.core                              dbus,
  output logic                                  core_halted
);

  import block_pkg::*;

  core_state_t                state;
  logic [imem_addr_width-1:0] pc;
  logic [data_width-1:0]      regs [reg_count];

  opcode_t                    opcode;
  logic [reg_idx_width-1:0]   rd_idx;
  logic [reg_idx_width-1:0]   rs_idx;
  logic [imm_width-1:0]       imm;
  logic [data_width-1:0]      imm_sext;
  logic [data_width-1:0]      imm_zext;
  logic [data_width-1:0]      rd_val;
  logic [data_width-1:0]      rs_val;
  logic [data_width-1:0]      eff_addr;
  logic                       core_reset;
  logic                       exec_ld;
  logic                       exec_st;
  logic                       reg_we;
  logic [data_width-1:0]      reg_wdata;

  assign core_reset = sys_rst || core_rst;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////
  // Instruction word is valid in st_exec and st_load_wait, pc is held
  assign opcode   = opcode_t'(imem_rd_data[op_msb:op_lsb]);
  assign rd_idx   = imem_rd_data[rd_msb:rd_lsb];
  assign rs_idx   = imem_rd_data[rs_msb:rs_lsb];
  assign imm      = imem_rd_data[imm_width-1:0];
  assign imm_sext = {{(data_width-imm_width){imm[imm_width-1]}}, imm};
  assign imm_zext = {{(data_width-imm_width){1'b0}}, imm};
  assign rd_val   = regs[rd_idx];
  assign rs_val   = regs[rs_idx];
  assign eff_addr = rs_val + imm_sext;

  assign exec_ld = (state == st_exec) && (opcode == op_ld);
  assign exec_st = (state == st_exec) && (opcode == op_st);

  // Data bus request, a single cycle strobe from st_exec
  assign dbus.en      = exec_ld || exec_st;
  assign dbus.wen     = exec_st;
  assign dbus.strb    = {strb_width{1'b1}};
  assign dbus.addr    = eff_addr[addr_width-1:0];
  assign dbus.wr_data = rd_val;

  assign imem_addr   = pc;
  assign core_halted = (state == st_halted);

  //////////////////////////////////////////////////////////////////////
  // FSM and program counter
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (core_reset) begin
      state <= st_fetch;
      pc    <= '0;
    end else begin
      case (state)
        st_fetch: state <= st_exec;
        st_exec: begin
          case (opcode)
            op_ld:   state <= st_load_wait;
            op_halt: state <= st_halted;
            op_bnz: begin
              pc    <= (rd_val != '0) ? imm[imem_addr_width-1:0] : pc + 1'b1;
              state <= st_fetch;
            end
            default: begin
              pc    <= pc + 1'b1;
              state <= st_fetch;
            end
          endcase
        end
        st_load_wait: begin
          if (dbus.rd_valid) begin
            pc    <= pc + 1'b1;
            state <= st_fetch;
          end
        end
        default: state <= st_halted;
      endcase
    end
  end

  // Register file write port
  always_comb begin
    reg_we    = 1'b0;
    reg_wdata = dbus.rd_data;
    if (state == st_exec) begin
      case (opcode)
        op_li: begin
          reg_we    = 1'b1;
          reg_wdata = imm_zext;
        end
        op_addi: begin
          reg_we    = 1'b1;
          reg_wdata = rd_val + imm_sext;
        end
        op_add: begin
          reg_we    = 1'b1;
          reg_wdata = rd_val + rs_val;
        end
        default: reg_we = 1'b0;
      endcase
    end else if (state == st_load_wait) begin
      reg_we = dbus.rd_valid;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reg_we && !core_reset) begin
      regs[rd_idx] <= reg_wdata;
    end
  end

  // A load keeps the bus quiet until its data is back
  assert property (@(posedge sys_clk) disable iff (core_reset)
    exec_ld |=> dbus.rd_valid && !dbus.en);

endmodule

// File: src/proc_block.sv
`timescale 1ns/10ps

module proc_block (
  input  logic                                 sys_clk,
  input  logic                                 sys_rst,
  input  logic                                 core_rst,
  input  logic [block_pkg::core_id_width-1:0]  core_id,

  // DMA access to both memories
  input  logic                                 dma_wr_en,
  input  logic [block_pkg::dma_addr_width-1:0] dma_wr_addr,
  input  logic [block_pkg::data_width-1:0]     dma_wr_data,
  input  logic [block_pkg::strb_width-1:0]     dma_wr_strb,
  input  logic                                 dma_rd_en,
  input  logic [block_pkg::dma_addr_width-1:0] dma_rd_addr,
  output logic                                 dma_rd_resp_valid,
  output logic [block_pkg::data_width-1:0]     dma_rd_resp_data,

  // Descriptors
  input  logic [block_pkg::data_width-1:0]     in_desc,
  input  logic                                 in_desc_valid,
  output logic                                 in_desc_taken,
  output logic [block_pkg::data_width-1:0]     out_desc,
  output logic                                 out_desc_valid,
  input  logic                                 out_desc_ready,

  output logic                                 core_halted
);

  import block_pkg::*;

  dmem_bus_if core_bus ();
  dmem_bus_if mem_bus ();
  dmem_bus_if io_bus ();

  logic [imem_addr_width-1:0] imem_addr;
  logic [data_width-1:0]      imem_rd_data;
  logic                       io_not_mem;
  logic                       io_read;
  logic                       io_read_r;

  //////////////////////////////////////////////////////////////////////
  // Core
  //////////////////////////////////////////////////////////////////////
  mini_core core (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .core_rst    (core_rst),
    .imem_addr   (imem_addr),
    .imem_rd_data(imem_rd_data),
    .dbus        (core_bus),
    .core_halted (core_halted)
  );

  //////////////////////////////////////////////////////////////////////
  // IO / memory split
  //////////////////////////////////////////////////////////////////////
  assign io_not_mem = (core_bus.addr & io_base) == io_base;
  assign io_read    = io_not_mem && core_bus.en && !core_bus.wen;

  assign mem_bus.en      = core_bus.en && !io_not_mem;
  assign mem_bus.wen     = core_bus.wen;
  assign mem_bus.strb    = core_bus.strb;
  assign mem_bus.addr    = core_bus.addr;
  assign mem_bus.wr_data = core_bus.wr_data;

  assign io_bus.en      = core_bus.en && io_not_mem;
  assign io_bus.wen     = core_bus.wen;
  assign io_bus.strb    = core_bus.strb;
  assign io_bus.addr    = core_bus.addr;
  assign io_bus.wr_data = core_bus.wr_data;

  // IO data comes back next cycle, steer the return path to match
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      io_read_r <= 1'b0;
    end else begin
      io_read_r <= io_read;
    end
  end

  assign core_bus.rd_data  = io_read_r ? io_bus.rd_data : mem_bus.rd_data;
  assign core_bus.rd_valid = io_read_r ? io_bus.rd_valid : mem_bus.rd_valid;

  mem_sys memories (
    .sys_clk          (sys_clk),
    .sys_rst          (sys_rst),
    .dma_wr_en        (dma_wr_en),
    .dma_wr_addr      (dma_wr_addr),
    .dma_wr_data      (dma_wr_data),
    .dma_wr_strb      (dma_wr_strb),
    .dma_rd_en        (dma_rd_en),
    .dma_rd_addr      (dma_rd_addr),
    .dma_rd_resp_valid(dma_rd_resp_valid),
    .dma_rd_resp_data (dma_rd_resp_data),
    .imem_addr        (imem_addr),
    .imem_rd_data     (imem_rd_data),
    .dbus             (mem_bus)
  );

  io_regs io (
    .sys_clk       (sys_clk),
    .sys_rst       (sys_rst),
    .dbus          (io_bus),
    .core_id       (core_id),
    .in_desc       (in_desc),
    .in_desc_valid (in_desc_valid),
    .in_desc_taken (in_desc_taken),
    .out_desc      (out_desc),
    .out_desc_valid(out_desc_valid),
    .out_desc_ready(out_desc_ready)
  );

endmodule

// File: tests/tb_proc_block.sv
`timescale 1ns/10ps

module tb_proc_block;

  import block_pkg::*;

  localparam int clk_half     = 10;
  localparam int reset_cycles = 10;
  localparam int n_dma_ops    = 48;
  localparam int n_sum_words  = 8;
  localparam int sum_base     = 16;
  localparam int sum_result   = 64;
  localparam int status_word  = 80;
  localparam int n_desc       = 12;
  localparam int imem_flag    = 1 << (dma_addr_width - 1);
  localparam int io_word      = 768;
  // The watchdog limit is the sum of the per-test cycle budgets
  localparam int prog_budget   = 400;
  localparam int desc_budget   = 120;
  localparam int timeout_limit = reset_cycles + 2 * dmem_words + 4 * n_dma_ops
                               + 3 * prog_budget + n_desc * desc_budget;

  logic                      sys_clk = 1'b0;
  logic                      sys_rst;
  logic                      core_rst;
  logic [core_id_width-1:0]  core_id;
  logic                      dma_wr_en;
  logic [dma_addr_width-1:0] dma_wr_addr;
  logic [data_width-1:0]     dma_wr_data;
  logic [strb_width-1:0]     dma_wr_strb;
  logic                      dma_rd_en;
  logic [dma_addr_width-1:0] dma_rd_addr;
  logic                      dma_rd_resp_valid;
  logic [data_width-1:0]     dma_rd_resp_data;
  logic [data_width-1:0]     in_desc;
  logic                      in_desc_valid;
  logic                      in_desc_taken;
  logic [data_width-1:0]     out_desc;
  logic                      out_desc_valid;
  logic                      out_desc_ready;
  logic                      core_halted;

  logic [data_width-1:0] dmem_model [dmem_words];
  logic [data_width-1:0] prog_buf [$];
  logic [15:0]           lfsr;
  int                    cycles = 0;
  int                    checks = 0;
  int                    errors = 0;

  proc_block dut0 (.*);

  initial begin
    forever #clk_half sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [data_width-1:0] apply_strobe(
    input logic [data_width-1:0] old_word,
    input logic [data_width-1:0] wr_word,
    input logic [strb_width-1:0] strb
  );
    logic [data_width-1:0] mask;
    mask = '0;
    for (int b = 0; b < strb_width; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (old_word & ~mask) | (wr_word & mask);
  endfunction

  function automatic logic [data_width-1:0] fill_word(input int addr);
    return (32'(addr) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  // opcode, rd, rs, six spare bits, immediate
  function automatic logic [data_width-1:0] encode(input opcode_t op, input int rd,
                                                   input int rs, input int imm);
    logic [31:0] rd_w;
    logic [31:0] rs_w;
    logic [31:0] imm_w;
    rd_w  = rd;
    rs_w  = rs;
    imm_w = imm;
    return {op, rd_w[2:0], rs_w[2:0], 6'b000000, imm_w[15:0]};
  endfunction

  task automatic check_word(input string what, input logic [data_width-1:0] got,
                            input logic [data_width-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // All bus tasks start and end on a falling edge
  task automatic dma_write(input logic [dma_addr_width-1:0] addr,
                           input logic [data_width-1:0] data,
                           input logic [strb_width-1:0] strb);
    dma_wr_en   = 1'b1;
    dma_wr_addr = addr;
    dma_wr_data = data;
    dma_wr_strb = strb;
    @(negedge sys_clk);
    dma_wr_en = 1'b0;
  endtask

  task automatic dma_read(input logic [dma_addr_width-1:0] addr,
                          output logic [data_width-1:0] data);
    dma_rd_en   = 1'b1;
    dma_rd_addr = addr;
    @(negedge sys_clk);
    dma_rd_en = 1'b0;
    check_bit("dma_rd_resp_valid", dma_rd_resp_valid, 1'b1);
    data = dma_rd_resp_data;
  endtask

  // Program words are read back through DMA before the core runs
  task automatic load_program();
    logic [data_width-1:0] got;
    for (int i = 0; i < prog_buf.size(); i++) begin
      dma_write(dma_addr_width'(imem_flag + i), prog_buf[i], '1);
    end
    for (int i = 0; i < prog_buf.size(); i++) begin
      dma_read(dma_addr_width'(imem_flag + i), got);
      check_word($sformatf("instruction word %0d", i), got, prog_buf[i]);
    end
    prog_buf.delete();
  endtask

  task automatic run_program();
    core_rst = 1'b0;
    while (!core_halted) begin
      @(negedge sys_clk);
    end
    core_rst = 1'b1;
    @(negedge sys_clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////
  task automatic reset_values();
    int e0;
    e0 = errors;
    check_bit("dma_rd_resp_valid after reset", dma_rd_resp_valid, 1'b0);
    check_bit("out_desc_valid after reset", out_desc_valid, 1'b0);
    check_bit("in_desc_taken after reset", in_desc_taken, 1'b0);
    check_bit("core_halted after reset", core_halted, 1'b0);
    report_test("1 reset", e0);
  endtask

  task automatic dma_roundtrip();
    int e0;
    logic [dmem_addr_width-1:0] addrs [n_dma_ops];
    logic [31:0]                r;
    logic [data_width-1:0]      data;
    logic [strb_width-1:0]      strb;
    logic [data_width-1:0]      got;
    e0 = errors;
    for (int i = 0; i < dmem_words; i++) begin
      dmem_model[i] = fill_word(i);
      dma_write(dma_addr_width'(i), dmem_model[i], '1);
    end
    for (int i = 0; i < n_dma_ops; i++) begin
      r        = rand_bits(dmem_addr_width);
      addrs[i] = r[dmem_addr_width-1:0];
      data     = rand_bits(data_width);
      r        = rand_bits(strb_width);
      strb     = r[strb_width-1:0];
      dmem_model[addrs[i]] = apply_strobe(dmem_model[addrs[i]], data, strb);
      dma_write({2'b00, addrs[i]}, data, strb);
    end
    for (int i = 0; i < n_dma_ops; i++) begin
      dma_read({2'b00, addrs[i]}, got);
      check_word($sformatf("data word %0d", addrs[i]), got, dmem_model[addrs[i]]);
    end
    report_test("2 dma", e0);
  endtask

  task automatic sum_program();
    int                    e0;
    logic [data_width-1:0] sum;
    logic [data_width-1:0] got;
    e0  = errors;
    sum = '0;
    for (int i = 0; i < n_sum_words; i++) begin
      dmem_model[sum_base + i] = rand_bits(data_width);
      sum += dmem_model[sum_base + i];
      dma_write(dma_addr_width'(sum_base + i), dmem_model[sum_base + i], '1);
    end
    prog_buf.push_back(encode(op_li, 1, 0, sum_base));
    prog_buf.push_back(encode(op_li, 2, 0, n_sum_words));
    prog_buf.push_back(encode(op_li, 3, 0, 0));
    // Loop body at word 3
    prog_buf.push_back(encode(op_ld, 4, 1, 0));
    prog_buf.push_back(encode(op_add, 3, 4, 0));
    prog_buf.push_back(encode(op_addi, 1, 0, 1));
    prog_buf.push_back(encode(op_addi, 2, 0, -1));
    prog_buf.push_back(encode(op_bnz, 2, 0, 3));
    prog_buf.push_back(encode(op_li, 5, 0, 0));
    prog_buf.push_back(encode(op_st, 3, 5, sum_result));
    prog_buf.push_back(encode(op_halt, 0, 0, 0));
    load_program();
    run_program();
    dma_read(dma_addr_width'(sum_result), got);
    check_word("sum result", got, sum);
    dmem_model[sum_result] = sum;
    report_test("3 sum program", e0);
  endtask

  task automatic descriptor_loop();
    int                    e0;
    int                    taken_cnt;
    int                    out_cnt;
    logic [data_width-1:0] descs [n_desc];
    logic [31:0]           r;
    logic [15:0]           kimm;
    logic [data_width-1:0] kext;
    e0        = errors;
    taken_cnt = 0;
    out_cnt   = 0;
    r    = rand_bits(16);
    kimm = r[15:0];
    kext = {{16{kimm[15]}}, kimm};
    for (int i = 0; i < n_desc; i++) begin
      descs[i] = rand_bits(data_width);
    end
    prog_buf.push_back(encode(op_li, 6, 0, io_word));
    prog_buf.push_back(encode(op_li, 2, 0, n_desc));
    prog_buf.push_back(encode(op_li, 7, 0, 1));
    // Wait for a descriptor at word 3
    prog_buf.push_back(encode(op_ld, 1, 6, int'(io_in_status)));
    prog_buf.push_back(encode(op_bnz, 1, 0, 6));
    prog_buf.push_back(encode(op_bnz, 7, 0, 3));
    prog_buf.push_back(encode(op_ld, 3, 6, int'(io_in_desc)));
    prog_buf.push_back(encode(op_addi, 3, 0, int'(kimm)));
    // Poll out pending at word 8 with the core_id bits subtracted
    prog_buf.push_back(encode(op_ld, 1, 6, int'(io_status)));
    prog_buf.push_back(encode(op_addi, 1, 0, -(int'(core_id) * 16)));
    prog_buf.push_back(encode(op_bnz, 1, 0, 8));
    prog_buf.push_back(encode(op_st, 3, 6, int'(io_out_desc)));
    prog_buf.push_back(encode(op_addi, 2, 0, -1));
    prog_buf.push_back(encode(op_bnz, 2, 0, 3));
    prog_buf.push_back(encode(op_halt, 0, 0, 0));
    load_program();
    in_desc       = descs[0];
    in_desc_valid = 1'b1;
    core_rst      = 1'b0;
    while (!(core_halted && !out_desc_valid)) begin
      @(negedge sys_clk);
      if (in_desc_taken) begin
        taken_cnt++;
        if (taken_cnt < n_desc) begin
          in_desc = descs[taken_cnt];
        end else begin
          in_desc_valid = 1'b0;
        end
      end
      r              = rand_bits(1);
      out_desc_ready = r[0];
      // Transfer happens on the coming rising edge
      if (out_desc_valid && out_desc_ready) begin
        if (out_cnt < n_desc) begin
          check_word($sformatf("out_desc %0d", out_cnt), out_desc, descs[out_cnt] + kext);
        end else begin
          errors++;
          $display("An output descriptor appeared beyond the %0d expected", n_desc);
        end
        out_cnt++;
      end
    end
    out_desc_ready = 1'b0;
    core_rst       = 1'b1;
    @(negedge sys_clk);
    checks++;
    if (taken_cnt != n_desc || out_cnt != n_desc) begin
      errors++;
      $display("Descriptor counts are wrong: %0d taken and %0d sent out of %0d",
               taken_cnt, out_cnt, n_desc);
    end
    report_test("4 descriptor loop", e0);
  endtask

  task automatic status_readback();
    int                    e0;
    logic [data_width-1:0] got;
    e0 = errors;
    prog_buf.push_back(encode(op_li, 6, 0, io_word));
    prog_buf.push_back(encode(op_ld, 1, 6, int'(io_status)));
    prog_buf.push_back(encode(op_li, 5, 0, 0));
    prog_buf.push_back(encode(op_st, 1, 5, status_word));
    prog_buf.push_back(encode(op_halt, 0, 0, 0));
    load_program();
    run_program();
    dma_read(dma_addr_width'(status_word), got);
    check_word("status word", got, {{(data_width-8){1'b0}}, core_id, 4'b0000});
    check_bit("status out pending", got[0], 1'b0);
    report_test("5 status", e0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] id_bits;
    lfsr           = 16'd6238;
    id_bits        = rand_bits(core_id_width);
    sys_rst        = 1'b1;
    core_rst       = 1'b1;
    core_id        = id_bits[core_id_width-1:0];
    dma_wr_en      = 1'b0;
    dma_wr_addr    = '0;
    dma_wr_data    = '0;
    dma_wr_strb    = '0;
    dma_rd_en      = 1'b0;
    dma_rd_addr    = '0;
    in_desc        = '0;
    in_desc_valid  = 1'b0;
    out_desc_ready = 1'b0;
    repeat (reset_cycles) @(negedge sys_clk);
    sys_rst = 1'b0;
    @(negedge sys_clk);

    reset_values();
    dma_roundtrip();
    sum_program();
    descriptor_loop();
    status_readback();

    $display("Checks run: %0d, failed: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
